/* common/spi_reg_defines.svh */
`ifndef SPI_REG_DEFINES_SVH
`define SPI_REG_DEFINES_SVH

// Size of the register map seen over SPI
`define REG_COUNT 16

// Address bits carried in the low nibble of the command byte
`define REG_ADDR_W 4

// Fixed identification byte returned by the last register
`define REG_ID_VALUE 8'h5A

// Flops in each pin synchronizer chain
// Three stages keep metastability risk low at typical clk rates
`define SYNC_STAGES 3

`endif

/* common/reg_map_pkg.sv */
`include "spi_reg_defines.svh"

// Register map types, used by the decoder, the bank and the byte link
package reg_map_pkg;

	// Register address, taken from the low bits of the command byte
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// One register holds one SPI byte
	typedef logic [7:0] reg_data_t;

	// Register 0 is mirrored onto the output pin bus
	localparam reg_addr_t REG_CTRL = reg_addr_t'(0);

	// The last register is read-only and returns the identification byte
	localparam reg_addr_t REG_ID = reg_addr_t'(`REG_COUNT - 1);

	// Every other index is a plain read/write scratch register

endpackage

/* common/spi_link_pkg.sv */
// Serial link types shared by the transceiver side and the command decoder
package spi_link_pkg;

	// Command opcode, carried in bits 7..6 of the first byte of a frame
	typedef enum logic [1:0] {
		OP_NOP   = 2'b00,	// Frame is ignored until CS rises
		OP_WRITE = 2'b01,	// Following bytes are written to the register bank
		OP_READ  = 2'b10,	// Following bytes clock register values out on MISO
		OP_RSVD  = 2'b11	// Reserved, handled the same as a NOP
	} spi_opcode_t;

	// Decoder frame state
	typedef enum logic [2:0] {
		ST_IDLE,	// CS is high, nothing in progress
		ST_CMD,		// Waiting for the command byte
		ST_WRITE,	// Each byte becomes a register write
		ST_READ,	// Each byte triggers a reload from the next address
		ST_DROP		// Rest of the frame is discarded
	} dec_state_t;

endpackage

/* common/spi_byte_if.sv */
`timescale 1ns/1ps

// Byte-wide link between the SPI transceiver and the command decoder
// All signals are plain strobes, there is no back-pressure in either direction
interface spi_byte_if import reg_map_pkg::*; ();

	reg_data_t	rx_data;	// Last complete byte received from MOSI
	logic		rx_valid;	// One clock pulse when rx_data has just been updated
	logic		cs_falling;	// One clock pulse at the start of every frame

	reg_data_t	tx_data;	// Next byte to shift out on MISO
	logic		tx_valid;	// Loads tx_data into the transmit shifter, always accepted

	// Transceiver end
	modport xcvr (
		output rx_data, rx_valid, cs_falling,
		input  tx_data, tx_valid
	);

	// Decoder end
	modport dec (
		input  rx_data, rx_valid, cs_falling,
		output tx_data, tx_valid
	);

endinterface

/* spi_device/spi_device_interface.sv */
`timescale 1ns/1ps
`include "spi_reg_defines.svh"

// Oversampling SPI device transceiver, mode 0 only
// SCK is treated as data and sampled on clk, so clk must run at least 4x SCK
module spi_device_interface (
	input  logic	clk,
	input  logic	rst_n,
	input  logic	spi_sck,
	input  logic	spi_mosi,
	input  logic	spi_cs_n,
	output logic	spi_miso,
	output logic	cs_n_sync,	// Synchronized chip select, shared with the decoder
	spi_byte_if.xcvr	link
);

	// Bit 2 is CS_N, bit 1 is SCK, bit 0 is MOSI
	logic [2:0]	sync_q [`SYNC_STAGES];
	logic		sck_sync;
	logic		mosi_sync;

	logic		cs_q;	// Previous synchronized CS_N
	logic		sck_q;	// Previous synchronized SCK
	logic		cs_falling;
	logic		sck_rising;

	logic [2:0]	bit_cnt;	// Bits of the current byte seen so far
	logic [7:0]	rx_shift;
	logic [7:0]	tx_shift;

	// All three pins go through the same chain, one column per pin
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `SYNC_STAGES; i++)
				sync_q[i] <= 3'b100;	// CS_N idles high
		end else begin
			sync_q[0] <= {spi_cs_n, spi_sck, spi_mosi};
			for (int i = 1; i < `SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign cs_n_sync = sync_q[`SYNC_STAGES-1][2];
	assign sck_sync  = sync_q[`SYNC_STAGES-1][1];
	assign mosi_sync = sync_q[`SYNC_STAGES-1][0];

	// One more flop per line gives the edge detectors
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cs_q  <= 1'b1;
			sck_q <= 1'b0;
		end else begin
			cs_q  <= cs_n_sync;
			sck_q <= sck_sync;
		end
	end

	assign cs_falling = cs_q && !cs_n_sync;	// Start of frame, restarts bit counting
	assign sck_rising = !sck_q && sck_sync;	// Mode 0 sample point
	assign link.cs_falling = cs_falling;

	assign spi_miso = tx_shift[7];	// MSB first

	// Counter, strobe and transmit shifter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_cnt       <= 3'd0;
			link.rx_valid <= 1'b0;
			tx_shift      <= 8'h00;
		end else begin
			link.rx_valid <= 1'b0;

			if (cs_falling) begin
				bit_cnt  <= 3'd0;
				tx_shift <= link.tx_data;	// First MISO byte of the frame
			end

			if (sck_rising) begin
				bit_cnt  <= bit_cnt + 3'd1;	// Wraps to zero after the eighth bit
				tx_shift <= {tx_shift[6:0], 1'b0};
				if (bit_cnt == 3'd7)
					link.rx_valid <= 1'b1;
			end

			// A reload always wins over the shift on the same clock
			if (link.tx_valid)
				tx_shift <= link.tx_data;
		end
	end

	// Receive path holds only payload
	always_ff @(posedge clk) begin
		if (sck_rising) begin
			rx_shift <= {rx_shift[6:0], mosi_sync};
			if (bit_cnt == 3'd7)
				link.rx_data <= {rx_shift[6:0], mosi_sync};	// Includes the bit sampled now
		end
	end

	// A byte can only complete when the counter has just wrapped
	a_rx_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		link.rx_valid |-> bit_cnt == 3'd0)
		else $error("rx_valid with bit counter at %0d", bit_cnt);

endmodule

/* spi_device/spi_cmd_decoder.sv */
`timescale 1ns/1ps

// Frame sequencer for the SPI register port
// First byte of a frame is the command, later bytes are data for the chosen opcode
module spi_cmd_decoder import spi_link_pkg::*, reg_map_pkg::*; (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		cs_n_sync,	// Already synchronized in the transceiver
	spi_byte_if.dec		link,
	output logic		wr_en,
	output reg_addr_t	wr_addr,
	output reg_data_t	wr_data,
	output reg_addr_t	rd_addr,
	input  reg_data_t	rd_data
);

	dec_state_t		state;
	reg_addr_t		addr;		// Running register address for this frame
	spi_opcode_t	cmd_op;
	reg_addr_t		cmd_addr;

	// Command byte fields, bits 5..4 are ignored
	assign cmd_op   = spi_opcode_t'(link.rx_data[7:6]);
	assign cmd_addr = reg_addr_t'(link.rx_data[$bits(reg_addr_t)-1:0]);

	// On the command byte the bank is asked for the start address directly,
	// afterwards it is always one ahead of the byte now on MISO
	assign rd_addr = (state == ST_CMD) ? cmd_addr : reg_addr_t'(addr + 1'b1);

	assign wr_addr = addr;	// Write lands at the current address, increment follows

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= ST_IDLE;
			addr          <= '0;
			wr_en         <= 1'b0;
			link.tx_valid <= 1'b0;
		end else begin
			wr_en         <= 1'b0;
			link.tx_valid <= 1'b0;

			if (link.cs_falling) begin
				state <= ST_CMD;
			end else if (cs_n_sync) begin
				state <= ST_IDLE;	// Frame over, whatever the state was
			end else begin
				case (state)
					ST_CMD: begin
						if (link.rx_valid) begin
							addr <= cmd_addr;
							case (cmd_op)
								OP_WRITE: state <= ST_WRITE;
								OP_READ: begin
									state         <= ST_READ;
									link.tx_valid <= 1'b1;	// rd_data of cmd_addr is latched below
								end
								default: state <= ST_DROP;	// NOP and the reserved code
							endcase
						end
					end
					ST_WRITE: begin
						if (link.rx_valid)
							wr_en <= 1'b1;
						if (wr_en)
							addr <= addr + 1'b1;	// Wraps modulo the register count
					end
					ST_READ: begin
						if (link.rx_valid) begin
							link.tx_valid <= 1'b1;
							addr          <= addr + 1'b1;
						end
					end
					default: ;	// ST_IDLE and ST_DROP wait for CS
				endcase
			end
		end
	end

	// Data path, captured with every received byte
	// Only used when the FSM raises wr_en or tx_valid on the following clock
	always_ff @(posedge clk) begin
		if (link.rx_valid) begin
			wr_data      <= link.rx_data;
			link.tx_data <= rd_data;
		end
	end

	a_wr_in_write: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> state == ST_WRITE)
		else $error("Register write outside a write frame");

	a_tx_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
		link.tx_valid |-> state != ST_IDLE)
		else $error("Transmit reload while idle");

endmodule

/* verilog/reg_bank.sv */
`timescale 1ns/1ps
`include "spi_reg_defines.svh"

// Sixteen byte registers, synchronous write and combinational read
module reg_bank import reg_map_pkg::*; (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		wr_en,
	input  reg_addr_t	wr_addr,
	input  reg_data_t	wr_data,
	input  reg_addr_t	rd_addr,
	output reg_data_t	rd_data,
	output reg_data_t	ctrl_out	// Mirror of REG_CTRL on the pin bus
);

	reg_data_t regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
			regs[REG_ID] <= `REG_ID_VALUE;	// Identification byte is loaded at reset
		end else if (wr_en && wr_addr != REG_ID) begin
			regs[wr_addr] <= wr_data;	// ID writes are dropped silently
		end
	end

	assign rd_data = regs[rd_addr];	// The ID register reads from storage like the others

	assign ctrl_out = regs[REG_CTRL];

	// A write aimed at the ID register must not disturb what is stored there
	a_id_read_only: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en && wr_addr == REG_ID |=> regs[REG_ID] == `REG_ID_VALUE)
		else $error("ID register changed after a write");

endmodule

/* verilog/spi_reg_top.sv */
`timescale 1ns/1ps

// SPI register port: transceiver, command decoder and register bank
module spi_reg_top import reg_map_pkg::*; (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		spi_sck,
	input  logic		spi_mosi,
	input  logic		spi_cs_n,
	output logic		spi_miso,
	output logic [7:0]	ctrl_out
);

	spi_byte_if link ();	// Byte stream between transceiver and decoder

	logic		cs_n_sync;
	logic		wr_en;
	reg_addr_t	wr_addr;
	reg_data_t	wr_data;
	reg_addr_t	rd_addr;
	reg_data_t	rd_data;

	spi_device_interface u_xcvr (
		.clk       (clk),
		.rst_n     (rst_n),
		.spi_sck   (spi_sck),
		.spi_mosi  (spi_mosi),
		.spi_cs_n  (spi_cs_n),
		.spi_miso  (spi_miso),
		.cs_n_sync (cs_n_sync),
		.link      (link.xcvr)
	);

	spi_cmd_decoder u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.cs_n_sync (cs_n_sync),
		.link      (link.dec),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	reg_bank u_execute (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.ctrl_out (ctrl_out)
	);

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free running testbench clock and a power-on reset
module tb_clock_gen #(
	parameter int PERIOD_NS  = 100,	// Full clk period
	parameter int RST_CYCLES = 5	// Rising edges seen with rst_n low
) (
	output logic	clk,
	output logic	rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Released on a falling edge so the next rising edge sees a settled rst_n
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* bench/spi_reg_tb.sv */
`timescale 1ns/1ps
`include "spi_reg_defines.svh"

// Testbench for the SPI register port
// A mode 0 master model sends frames and a reference register model predicts each MISO byte
module spi_reg_tb import spi_link_pkg::*, reg_map_pkg::*;;

	localparam int CLK_PERIOD_NS   = 100;
	localparam int SCK_HALF        = 4;	// clk cycles per SCK half period
	localparam int MAX_FRAME_BYTES = 17;	// Command byte plus a full sweep of the map
	localparam int N_FRAMES        = 59;	// Directed frames plus the random ones
	localparam int SCK_PERIOD_NS   = 2 * SCK_HALF * CLK_PERIOD_NS;
	localparam int FRAME_GAP_NS    = 16 * CLK_PERIOD_NS;	// CS setup, hold and idle time
	localparam int TIMEOUT_NS      = 10 * CLK_PERIOD_NS
		+ N_FRAMES * (MAX_FRAME_BYTES * 8 * SCK_PERIOD_NS + FRAME_GAP_NS) + 20000;

	logic		clk;
	logic		rst_n;
	logic		spi_sck;
	logic		spi_mosi;
	logic		spi_cs_n;
	logic		spi_miso;
	logic [7:0]	ctrl_out;

	reg_data_t	model [`REG_COUNT];	// Expected register contents
	logic [1:0]	ref_op;				// Opcode of the frame being modelled
	reg_addr_t	ref_addr;			// Running address of that frame
	logic [7:0]	frame_buf [MAX_FRAME_BYTES];	// MOSI bytes of the next frame

	// Exchanged bytes waiting for comparison, a position of -1 marks the end of a frame
	int			pos_q [$];
	logic [7:0]	mosi_q [$];
	logic [7:0]	miso_q [$];

	int			errors;
	int			checks;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(5)) u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	spi_reg_top dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.spi_miso (spi_miso),
		.ctrl_out (ctrl_out)
	);

	// Opcode in bits 7..6, filler in 5..4, address in 3..0
	function automatic logic [7:0] cmd_byte(input logic [1:0] op, input logic [3:0] addr,
			input logic [1:0] pad);
		return {op, pad, addr};
	endfunction

	// Returns {care, expected MISO} for byte pos of a frame and applies writes to the model
	function automatic logic [8:0] ref_response(input int pos, input logic [7:0] mosi);
		logic [8:0] res;
		res = 9'h000;	// Don't care unless a read frame says otherwise
		if (pos == 0) begin
			ref_op   = mosi[7:6];
			ref_addr = mosi[3:0];
		end else if (ref_op == OP_WRITE) begin
			if (ref_addr != REG_ID)
				model[ref_addr] = mosi;	// ID register stays constant
			ref_addr = ref_addr + 1'b1;	// Wraps after the last register
		end else if (ref_op == OP_READ) begin
			res      = {1'b1, model[ref_addr]};
			ref_addr = ref_addr + 1'b1;
		end
		return res;	// NOP and reserved frames predict nothing
	endfunction

	task automatic report_mismatch(input string what, input logic [7:0] expected,
			input logic [7:0] actual);
		errors++;
		$display("** Error at %0t: %s, expected %02h, actual %02h", $time, what,
			expected, actual);
	endtask

	task automatic fill_random(input int first, input int count);
		for (int i = first; i < first + count; i++)
			frame_buf[i] = 8'($urandom);
	endtask

	// One CS frame, every input changes on a falling clk edge
	task automatic send_frame(input int nbytes);
		logic [7:0] rx_byte;
		@(negedge clk);
		spi_cs_n = 1'b0;
		repeat (4) @(negedge clk);
		for (int b = 0; b < nbytes; b++) begin
			for (int i = 7; i >= 0; i--) begin
				spi_sck  = 1'b0;
				spi_mosi = frame_buf[b][i];	// MOSI set while SCK is low
				repeat (SCK_HALF) @(negedge clk);
				rx_byte[i] = spi_miso;	// Sampled where SCK rises
				spi_sck    = 1'b1;
				repeat (SCK_HALF) @(negedge clk);
			end
			pos_q.push_back(b);
			mosi_q.push_back(frame_buf[b]);
			miso_q.push_back(rx_byte);
		end
		spi_sck = 1'b0;
		repeat (4) @(negedge clk);
		spi_cs_n = 1'b1;
		repeat (4) @(negedge clk);
		pos_q.push_back(-1);	// ctrl_out is checked once CS is back high
		mosi_q.push_back(8'h00);
		miso_q.push_back(8'h00);
	endtask

	// Comparison process, drains the queue on every falling edge
	initial begin : compare_proc
		int			pos;
		logic [7:0]	mosi;
		logic [7:0]	miso;
		logic [8:0]	exp;
		forever begin
			@(negedge clk);
			while (pos_q.size() > 0) begin
				pos  = pos_q.pop_front();
				mosi = mosi_q.pop_front();
				miso = miso_q.pop_front();
				if (pos < 0) begin
					checks++;
					if (ctrl_out !== model[REG_CTRL])
						report_mismatch("ctrl_out after frame", model[REG_CTRL], ctrl_out);
				end else begin
					exp = ref_response(pos, mosi);
					if (exp[8]) begin
						checks++;
						if (miso !== exp[7:0])
							report_mismatch($sformatf("MISO byte %0d", pos), exp[7:0], miso);
					end
				end
			end
		end
	end

	// Watchdog sized from the worst case frame length
	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the frame sequence did not finish within %0d ns", TIMEOUT_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main_seq
		reg_addr_t	start;
		int			nbytes;
		spi_sck  = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_n = 1'b1;	// No frame during reset
		errors   = 0;
		checks   = 0;
		void'($urandom(66));
		for (int i = 0; i < `REG_COUNT; i++)
			model[i] = 8'h00;
		model[REG_ID] = `REG_ID_VALUE;
		ref_op   = OP_NOP;
		ref_addr = '0;
		frame_buf[1] = 8'h00;
		wait (rst_n === 1'b1);
		repeat (2) @(negedge clk);

		// Reset values, ID register and a cleared control register
		frame_buf[0] = cmd_byte(OP_READ, REG_ID, 2'b00);
		send_frame(2);
		frame_buf[0] = cmd_byte(OP_READ, REG_CTRL, 2'b00);
		send_frame(2);

		// Single write to the control register, then read back with filler bits set
		frame_buf[0] = cmd_byte(OP_WRITE, REG_CTRL, 2'b00);
		fill_random(1, 1);
		send_frame(2);
		frame_buf[0] = cmd_byte(OP_READ, REG_CTRL, 2'b11);
		send_frame(2);

		// Burst long enough to run across the ID register and wrap to zero
		start        = reg_addr_t'(8 + $urandom_range(0, 6));
		frame_buf[0] = cmd_byte(OP_WRITE, start, 2'b00);
		fill_random(1, 12);
		send_frame(13);
		frame_buf[0] = cmd_byte(OP_READ, start, 2'b00);
		fill_random(1, 12);
		send_frame(13);

		// NOP and reserved frames carry data that must be dropped
		frame_buf[0] = cmd_byte(OP_NOP, 4'h3, 2'b00);
		fill_random(1, 4);
		send_frame(5);
		frame_buf[0] = cmd_byte(OP_RSVD, REG_CTRL, 2'b01);
		fill_random(1, 4);
		send_frame(5);
		frame_buf[0] = cmd_byte(OP_READ, REG_CTRL, 2'b00);
		fill_random(1, 16);
		send_frame(17);	// Full sweep of the map

		// Random opcode, address and length
		for (int f = 0; f < 50; f++) begin
			nbytes       = $urandom_range(1, 6);
			frame_buf[0] = cmd_byte(2'($urandom_range(0, 3)), 4'($urandom), 2'($urandom));
			fill_random(1, nbytes - 1);
			send_frame(nbytes);
		end

		while (pos_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+common
common/reg_map_pkg.sv
common/spi_link_pkg.sv
common/spi_byte_if.sv
spi_device/spi_device_interface.sv
spi_device/spi_cmd_decoder.sv
verilog/reg_bank.sv
verilog/spi_reg_top.sv
bench/tb_clock_gen.sv
bench/spi_reg_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the SPI register port testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=spi_reg_sim
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module spi_reg_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
